/* logic/cpu_pkg.sv */
// cpu_pkg: word widths, opcode decode constants, sequencer states and KC/PC timing
`default_nettype none

package cpu_pkg;

	localparam int WORD_W   = 16;
	localparam int ADDR_W   = 16;
	localparam int OPCODE_W = 6;

	typedef logic [WORD_W-1:0]   word_t;
	typedef logic [ADDR_W-1:0]   addr_t;
	typedef logic [OPCODE_W-1:0] opcode_t;

	// opcode sits in the top bits of the instruction word
	localparam opcode_t OP_HLT = 6'o00;

	// set in an instruction word when an argument word follows
	localparam int TWO_WORD_BIT = 9;

	// IC value after interrupt receive
	localparam addr_t INT_VECTOR = 16'h0040;

	// univibrator lengths, in clocks
	localparam int KC_TICKS = 3;
	localparam int PC_TICKS = 2;
	localparam int TICK_MAX = (KC_TICKS > PC_TICKS) ? KC_TICKS : PC_TICKS;
	localparam int TICK_W   = $clog2(TICK_MAX + 1);

	typedef logic [TICK_W-1:0] tick_t;

	// P0 idle/wait, P1 instruction fetch, P2 argument fetch, P3 execute, PK cycle end
	typedef enum logic [2:0] {
		P0,
		P1,
		P2,
		P3,
		PK
	} pm_state_e;

endpackage

`default_nettype wire

/* logic/membus_pkg.sv */
// membus_pkg: memory port request/response, panel command and P-M status structs
`default_nettype none

package membus_pkg;

	import cpu_pkg::*;

	// held steady by the requester until ack
	typedef struct packed {
		logic  req;
		logic  we;
		addr_t addr;
		word_t wdata;
	} mem_req_t;

	// ack is a one-cycle pulse, rdata valid with it
	typedef struct packed {
		logic  ack;
		word_t rdata;
	} mem_rsp_t;

	// load/store/fetch are single-cycle strobes
	typedef struct packed {
		logic  load;
		logic  store;
		logic  fetch;
		addr_t addr;
		word_t data;
	} panel_cmd_t;

	typedef struct packed {
		logic      run;
		logic      wait_q;
		logic      przerw;
		pm_state_e state;
		addr_t     ic;
		word_t     ir;
		word_t     ar;
	} pm_status_t;

endpackage

`default_nettype wire

/* logic/cycle_timer.sv */
// cycle_timer: KC (cycle end) and PC (cycle start) pulse generators
`timescale 1ns/1ps
`default_nettype none

module cycle_timer (
	input  logic __clk,
	input  logic rst_n,
	input  logic cycle_end,
	output logic kc,
	output logic pc
);

	import cpu_pkg::*;

	// one counter serves both univibrators, they never overlap
	tick_t cnt;

	always_ff @(posedge __clk or negedge rst_n) begin
		if (!rst_n) begin
			kc  <= 1'b0;
			pc  <= 1'b0;
			cnt <= '0;
		end else if (kc) begin
			if (cnt == tick_t'(KC_TICKS - 1)) begin
				// KC falling edge fires PC
				kc  <= 1'b0;
				pc  <= 1'b1;
				cnt <= '0;
			end else begin
				cnt <= cnt + tick_t'(1);
			end
		end else if (pc) begin
			if (cnt == tick_t'(PC_TICKS - 1)) begin
				pc  <= 1'b0;
				cnt <= '0;
			end else begin
				cnt <= cnt + tick_t'(1);
			end
		end else if (cycle_end) begin
			// triggers during a running pulse never get here
			kc  <= 1'b1;
			cnt <= '0;
		end
	end

endmodule

`default_nettype wire

/* logic/panel_control.sv */
// panel_control: operator panel LOAD/STORE/FETCH handling and its memory accesses
`timescale 1ns/1ps
`default_nettype none

module panel_control (
	input  logic                   __clk,
	input  logic                   rst_n,
	input  membus_pkg::panel_cmd_t panel,
	input  logic                   run,
	input  membus_pkg::mem_rsp_t   rsp,
	output membus_pkg::mem_req_t   req,
	output logic                   ic_load,
	output cpu_pkg::addr_t         ic_value,
	output cpu_pkg::word_t         panel_rdata,
	output logic                   panel_done
);

	import cpu_pkg::*;

	logic  store_q;
	logic  fetch_q;
	logic  busy;
	logic  accept;
	addr_t addr_q;
	word_t data_q;

	assign busy   = store_q | fetch_q;
	// panel is dead while running or with an access in flight
	assign accept = ~run & ~busy;

	// load goes straight to IC, no memory cycle
	assign ic_load  = panel.load & accept;
	assign ic_value = panel.addr;

	always_ff @(posedge __clk or negedge rst_n) begin
		if (!rst_n) begin
			store_q    <= 1'b0;
			fetch_q    <= 1'b0;
			panel_done <= 1'b0;
		end else begin
			panel_done <= rsp.ack & busy;
			if (rsp.ack) begin
				store_q <= 1'b0;
				fetch_q <= 1'b0;
			end else if (accept) begin
				// store wins if both strobes come together
				store_q <= panel.store;
				fetch_q <= panel.fetch & ~panel.store;
			end
		end
	end

	always_ff @(posedge __clk) begin
		if (accept && (panel.store || panel.fetch)) begin
			addr_q <= panel.addr;
			data_q <= panel.data;
		end
		if (rsp.ack && fetch_q) begin
			panel_rdata <= rsp.rdata;
		end
	end

	always_comb begin
		req.req   = busy;
		req.we    = store_q;
		req.addr  = addr_q;
		req.wdata = data_q;
	end

endmodule

`default_nettype wire

/* logic/mem_arbiter.sv */
// mem_arbiter: shares the single memory port between panel and sequencer
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
	input  logic                 __clk,
	input  logic                 rst_n,
	input  membus_pkg::mem_req_t panel_req,
	input  membus_pkg::mem_req_t seq_req,
	input  membus_pkg::mem_rsp_t mem_rsp,
	output membus_pkg::mem_rsp_t panel_rsp,
	output membus_pkg::mem_rsp_t seq_rsp,
	output membus_pkg::mem_req_t mem_req
);

	typedef enum logic [1:0] {
		GNT_IDLE,
		GNT_PANEL,
		GNT_SEQ
	} gnt_e;

	gnt_e grant;
	logic pick_panel;
	logic pick_seq;

	// idle cycle passes the winner through at once, then grant holds it
	always_comb begin
		pick_panel = 1'b0;
		pick_seq   = 1'b0;
		case (grant)
			GNT_PANEL: pick_panel = 1'b1;
			GNT_SEQ:   pick_seq = 1'b1;
			default: begin
				pick_panel = panel_req.req;
				pick_seq   = ~panel_req.req & seq_req.req;
			end
		endcase
	end

	always_ff @(posedge __clk or negedge rst_n) begin
		if (!rst_n) begin
			grant <= GNT_IDLE;
		end else begin
			case (grant)
				GNT_IDLE: begin
					if (panel_req.req)
						grant <= GNT_PANEL;
					else if (seq_req.req)
						grant <= GNT_SEQ;
				end
				default: begin
					if (mem_rsp.ack)
						grant <= GNT_IDLE;
				end
			endcase
		end
	end

	assign mem_req = pick_panel ? panel_req : (pick_seq ? seq_req : '0);

	// ack only reaches the owner of the grant
	always_comb begin
		panel_rsp.ack   = mem_rsp.ack & (grant == GNT_PANEL);
		panel_rsp.rdata = mem_rsp.rdata;
		seq_rsp.ack     = mem_rsp.ack & (grant == GNT_SEQ);
		seq_rsp.rdata   = mem_rsp.rdata;
	end

endmodule

`default_nettype wire

/* logic/state_sequencer.sv */
// state_sequencer: START/WAIT/PRZERW flip-flops and the P0-PK instruction cycle
`timescale 1ns/1ps
`default_nettype none

module state_sequencer (
	input  logic                   __clk,
	input  logic                   rst_n,
	input  logic                   start_key,
	input  logic                   stop_key,
	input  logic                   irq,
	input  logic                   kc,
	input  logic                   pc,
	input  membus_pkg::mem_rsp_t   rsp,
	input  logic                   ic_load,
	input  cpu_pkg::addr_t         ic_value,
	output membus_pkg::mem_req_t   req,
	output logic                   cycle_end,
	output logic                   irq_ack,
	output membus_pkg::pm_status_t status
);

	import cpu_pkg::*;

	pm_state_e state;
	logic      start_q;
	logic      wait_q;
	logic      przerw_q;
	logic      stop_q;
	addr_t     ic;
	word_t     ir;
	word_t     ar;
	logic      kc_d;
	logic      pc_d;
	logic      run;
	logic      kc_rise;
	logic      pc_fall;
	logic      cont;
	opcode_t   opcode;

	assign run     = start_q & ~wait_q;
	assign kc_rise = kc & ~kc_d;
	assign pc_fall = pc_d & ~pc;
	assign opcode  = ir[WORD_W-1 -: OPCODE_W];

	// run after this cycle end, with pending stop and interrupt applied
	assign cont = start_q & ~stop_q & (~wait_q | przerw_q);

	always_ff @(posedge __clk or negedge rst_n) begin
		if (!rst_n) begin
			kc_d <= 1'b0;
			pc_d <= 1'b0;
		end else begin
			kc_d <= kc;
			pc_d <= pc;
		end
	end

	// START, WAIT and the stop request
	always_ff @(posedge __clk or negedge rst_n) begin
		if (!rst_n) begin
			start_q <= 1'b0;
			wait_q  <= 1'b0;
			stop_q  <= 1'b0;
		end else if (start_key) begin
			start_q <= 1'b1;
			wait_q  <= 1'b0;
			stop_q  <= 1'b0;
		end else begin
			if (stop_key)
				stop_q <= 1'b1;
			// stop lands at cycle end, or at once when idle
			if (stop_q && (state == P0 || (state == PK && pc_fall))) begin
				start_q <= 1'b0;
				stop_q  <= 1'b0;
			end
			if (state == P3 && opcode == OP_HLT)
				wait_q <= 1'b1;
			else if (state == PK && pc_fall && przerw_q)
				wait_q <= 1'b0;
		end
	end

	// interrupt latched on KC rising, serviced when PC falls
	always_ff @(posedge __clk or negedge rst_n) begin
		if (!rst_n)
			przerw_q <= 1'b0;
		else if (kc_rise && irq && start_q)
			przerw_q <= 1'b1;
		else if (state == PK && pc_fall)
			przerw_q <= 1'b0;
	end

	always_ff @(posedge __clk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= P0;
			ic        <= '0;
			cycle_end <= 1'b0;
			irq_ack   <= 1'b0;
		end else begin
			cycle_end <= 1'b0;
			irq_ack   <= 1'b0;
			if (ic_load)
				ic <= ic_value;
			case (state)
				P0: begin
					if (run && !stop_q) begin
						state <= P1;
					end else if (start_q && irq) begin
						// dummy cycle end so a halted CPU can take the interrupt
						state     <= PK;
						cycle_end <= 1'b1;
					end
				end
				P1: begin
					if (rsp.ack) begin
						ic    <= ic + 16'd1;
						state <= rsp.rdata[TWO_WORD_BIT] ? P2 : P3;
					end
				end
				P2: begin
					if (rsp.ack) begin
						ic    <= ic + 16'd1;
						state <= P3;
					end
				end
				P3: begin
					state     <= PK;
					cycle_end <= 1'b1;
				end
				PK: begin
					if (pc_fall) begin
						if (przerw_q) begin
							ic      <= INT_VECTOR;
							irq_ack <= 1'b1;
						end
						state <= cont ? P1 : P0;
					end
				end
				default: state <= P0;
			endcase
		end
	end

	always_ff @(posedge __clk) begin
		if (state == P1 && rsp.ack)
			ir <= rsp.rdata;
		if (state == P2 && rsp.ack)
			ar <= rsp.rdata;
	end

	// sequencer only reads memory
	always_comb begin
		req.req   = (state == P1) || (state == P2);
		req.we    = 1'b0;
		req.addr  = ic;
		req.wdata = '0;
	end

	always_comb begin
		status.run    = run;
		status.wait_q = wait_q;
		status.przerw = przerw_q;
		status.state  = state;
		status.ic     = ic;
		status.ir     = ir;
		status.ar     = ar;
	end

endmodule

`default_nettype wire

/* logic/pm_top.sv */
// pm_top: P-M control unit with cycle timer, panel, memory arbiter and sequencer
`timescale 1ns/1ps
`default_nettype none

module pm_top (
	input  logic                   __clk,
	input  logic                   rst_n,
	input  logic                   start_key,
	input  logic                   stop_key,
	input  logic                   irq,
	input  membus_pkg::panel_cmd_t panel,
	input  membus_pkg::mem_rsp_t   mem_rsp,
	output membus_pkg::mem_req_t   mem_req,
	output logic                   irq_ack,
	output cpu_pkg::word_t         panel_rdata,
	output logic                   panel_done,
	output membus_pkg::pm_status_t status
);

	import cpu_pkg::*;
	import membus_pkg::*;

	mem_req_t panel_req;
	mem_req_t seq_req;
	mem_rsp_t panel_rsp;
	mem_rsp_t seq_rsp;
	logic     ic_load;
	addr_t    ic_value;
	logic     cycle_end;
	logic     kc;
	logic     pc;

	cycle_timer u_timer (
		.__clk     (__clk),
		.rst_n     (rst_n),
		.cycle_end (cycle_end),
		.kc        (kc),
		.pc        (pc)
	);

	panel_control u_panel (
		.__clk       (__clk),
		.rst_n       (rst_n),
		.panel       (panel),
		.run         (status.run),
		.rsp         (panel_rsp),
		.req         (panel_req),
		.ic_load     (ic_load),
		.ic_value    (ic_value),
		.panel_rdata (panel_rdata),
		.panel_done  (panel_done)
	);

	mem_arbiter u_arb (
		.__clk     (__clk),
		.rst_n     (rst_n),
		.panel_req (panel_req),
		.seq_req   (seq_req),
		.mem_rsp   (mem_rsp),
		.panel_rsp (panel_rsp),
		.seq_rsp   (seq_rsp),
		.mem_req   (mem_req)
	);

	state_sequencer u_seq (
		.__clk     (__clk),
		.rst_n     (rst_n),
		.start_key (start_key),
		.stop_key  (stop_key),
		.irq       (irq),
		.kc        (kc),
		.pc        (pc),
		.rsp       (seq_rsp),
		.ic_load   (ic_load),
		.ic_value  (ic_value),
		.req       (seq_req),
		.cycle_end (cycle_end),
		.irq_ack   (irq_ack),
		.status    (status)
	);

endmodule

`default_nettype wire

/* verification/pm_tb.sv */
// pm_tb: testbench for the P-M control unit with a variable-latency memory model
`timescale 1ns/1ps
`default_nettype none

module pm_tb;

	import cpu_pkg::*;
	import membus_pkg::*;

	// about 60 instructions of at most 14 clocks plus the panel phase, times three
	localparam int WATCHDOG_CYCLES = 4000;

	logic       clk = 1'b0;
	logic       rst_n;
	logic       start_key;
	logic       stop_key;
	logic       irq;
	panel_cmd_t panel;
	mem_rsp_t   mem_rsp = '0;
	mem_req_t   mem_req;
	logic       irq_ack;
	word_t      panel_rdata;
	logic       panel_done;
	pm_status_t status;

	// memory model
	word_t       mem [0:255];
	mem_req_t    acc;
	logic        pending = 1'b0;
	logic [1:0]  delay = 2'd0;
	logic [1:0]  pick;
	logic [31:0] lfsr = 32'haf1b_e032;

	// reference state for the checks
	logic       idle_phase;
	logic       fetch_armed;
	word_t      fetch_value;
	logic       seq_fetch;
	addr_t      exp_fetch;
	addr_t      next_fetch;
	word_t      exp_ir;
	word_t      exp_ar;
	opcode_t    ir_opcode;
	int         ack_count;
	int         kc_run;
	int         pc_run;
	logic       prev_kc;
	pm_state_e  prev_state;
	logic       prev_przerw;
	logic       prev_wait;
	logic       prev_ack;
	logic       prev_run;
	logic       prev_pending;
	mem_req_t   prev_req;
	panel_cmd_t prev_panel;

	pm_top DUT (
		.__clk       (clk),
		.rst_n       (rst_n),
		.start_key   (start_key),
		.stop_key    (stop_key),
		.irq         (irq),
		.panel       (panel),
		.mem_rsp     (mem_rsp),
		.mem_req     (mem_req),
		.irq_ack     (irq_ack),
		.panel_rdata (panel_rdata),
		.panel_done  (panel_done),
		.status      (status)
	);

	always #10 clk = ~clk;

	task automatic fail_now();
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input logic [63:0] exp,
			input logic [63:0] act);
		$display("** Error: %s expected %0h actual %0h", name, exp, act);
		fail_now();
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		fail_now();
	endtask

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// program words, everything else a one-word no-op tagged with its address
	function automatic word_t image_word(input int a);
		case (a)
			'h10: return 16'h0400;
			'h11: return 16'h0600;
			'h12: return 16'h1234;
			'h13: return 16'h0401;
			'h14: return 16'h0602;
			'h15: return 16'hcafe;
			'h16: return 16'h0000;
			'h40: return 16'h0410;
			'h41: return 16'h0611;
			'h42: return 16'ha5a5;
			'h43: return 16'h0000;
			default: return {6'o17, 2'b00, a[7:0]};
		endcase
	endfunction

	// ack comes 1 to 4 clocks after the request is seen
	always @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 256; i++)
				mem[i] <= image_word(i);
			mem_rsp <= '0;
			pending <= 1'b0;
		end else begin
			mem_rsp.ack <= 1'b0;
			if (pending) begin
				if (delay == 2'd0) begin
					mem_rsp.ack   <= 1'b1;
					mem_rsp.rdata <= mem[acc.addr[7:0]];
					if (acc.we)
						mem[acc.addr[7:0]] <= acc.wdata;
					pending <= 1'b0;
				end else begin
					delay <= delay - 2'd1;
				end
			end else if (mem_req.req && !mem_rsp.ack) begin
				lfsr = lfsr_next(lfsr);
				pick[0] = lfsr[0];
				lfsr = lfsr_next(lfsr);
				pick[1] = lfsr[0];
				acc     <= mem_req;
				pending <= 1'b1;
				delay   <= pick;
			end
		end
	end

	assign seq_fetch = mem_req.req && (status.state == P1 || status.state == P2);
	assign exp_fetch = irq_ack ? INT_VECTOR : next_fetch;
	assign ir_opcode = exp_ir[WORD_W-1 -: OPCODE_W];

	always @(posedge clk) begin
		if (!rst_n) begin
			next_fetch <= '0;
			ack_count  <= 0;
			kc_run     <= 0;
			pc_run     <= 0;
		end else begin
			kc_run <= DUT.kc ? kc_run + 1 : 0;
			pc_run <= DUT.pc ? pc_run + 1 : 0;
			if (irq_ack) begin
				next_fetch <= INT_VECTOR;
				ack_count  <= ack_count + 1;
			end else if (seq_fetch && mem_rsp.ack) begin
				next_fetch <= mem_req.addr + 16'd1;
			end else if (panel.load && !status.run && !mem_req.req) begin
				next_fetch <= panel.addr;
			end
			if (seq_fetch && mem_rsp.ack && status.state == P1)
				exp_ir <= mem[mem_req.addr[7:0]];
			if (seq_fetch && mem_rsp.ack && status.state == P2)
				exp_ar <= mem[mem_req.addr[7:0]];
		end
		prev_kc      <= DUT.kc;
		prev_state   <= status.state;
		prev_przerw  <= status.przerw;
		prev_wait    <= status.wait_q;
		prev_ack     <= irq_ack;
		prev_run     <= status.run;
		prev_pending <= mem_req.req && !mem_rsp.ack;
		prev_req     <= mem_req;
		prev_panel   <= panel;
	end

	reset_state: assert property (@(posedge clk) disable iff (!rst_n)
		idle_phase |-> {status.state, status.run, status.wait_q, status.przerw,
			status.ic, mem_req.req, irq_ack} == {P0, 3'b000, 16'h0000, 2'b00})
		else report_mismatch("reset_state", 64'({P0, 3'b000, 16'h0000, 2'b00}),
			64'($sampled({status.state, status.run, status.wait_q, status.przerw,
			status.ic, mem_req.req, irq_ack})));

	panel_fetch: assert property (@(posedge clk) disable iff (!rst_n)
		panel_done && fetch_armed |-> panel_rdata == fetch_value)
		else report_mismatch("panel_fetch", 64'($sampled(fetch_value)),
			64'($sampled(panel_rdata)));

	panel_load: assert property (@(posedge clk) disable iff (!rst_n)
		prev_panel.load && !prev_run && !prev_req.req |-> status.ic == prev_panel.addr)
		else report_mismatch("panel_load", 64'($sampled(prev_panel.addr)),
			64'($sampled(status.ic)));

	fetch_addr: assert property (@(posedge clk) disable iff (!rst_n)
		seq_fetch |-> mem_req.addr == exp_fetch)
		else report_mismatch("fetch_addr", 64'($sampled(exp_fetch)),
			64'($sampled(mem_req.addr)));

	ir_load: assert property (@(posedge clk) disable iff (!rst_n)
		status.state == P3 |-> status.ir == exp_ir)
		else report_mismatch("ir_load", 64'($sampled(exp_ir)), 64'($sampled(status.ir)));

	ar_load: assert property (@(posedge clk) disable iff (!rst_n)
		status.state == P3 && exp_ir[TWO_WORD_BIT] |-> status.ar == exp_ar)
		else report_mismatch("ar_load", 64'($sampled(exp_ar)), 64'($sampled(status.ar)));

	// execute is entered from the argument fetch exactly for two-word instructions
	two_word_decode: assert property (@(posedge clk) disable iff (!rst_n)
		status.state == P3 |-> prev_state == (exp_ir[TWO_WORD_BIT] ? P2 : P1))
		else report_mismatch("two_word_decode",
			64'($sampled(exp_ir[TWO_WORD_BIT]) ? P2 : P1), 64'($sampled(prev_state)));

	kc_width: assert property (@(posedge clk) disable iff (!rst_n)
		prev_kc && !DUT.kc |-> kc_run == KC_TICKS)
		else report_mismatch("kc_width", 64'(KC_TICKS), 64'($sampled(kc_run)));

	pc_follows_kc: assert property (@(posedge clk) disable iff (!rst_n)
		DUT.pc && pc_run == 0 |-> prev_kc && !DUT.kc)
		else report_mismatch("pc_follows_kc", 64'b10, 64'($sampled({prev_kc, DUT.kc})));

	pc_width: assert property (@(posedge clk) disable iff (!rst_n)
		!DUT.pc && pc_run != 0 |-> pc_run == PC_TICKS)
		else report_mismatch("pc_width", 64'(PC_TICKS), 64'($sampled(pc_run)));

	// only a halt opcode stops the CPU at its cycle end
	halt_sets_wait: assert property (@(posedge clk) disable iff (!rst_n)
		status.state == P3 |=> status.wait_q == (ir_opcode == OP_HLT))
		else report_mismatch("halt_sets_wait", 64'($sampled(ir_opcode == OP_HLT)),
			64'($sampled(status.wait_q)));

	halt_is_quiet: assert property (@(posedge clk) disable iff (!rst_n)
		status.state == P0 && status.wait_q |-> !mem_req.req && !status.run)
		else report_mismatch("halt_is_quiet", 64'd0,
			64'($sampled({mem_req.req, status.run})));

	halt_goes_idle: assert property (@(posedge clk) disable iff (!rst_n)
		prev_state == PK && prev_wait && !prev_przerw && status.state != PK
		|-> status.state == P0)
		else report_mismatch("halt_goes_idle", 64'(P0), 64'($sampled(status.state)));

	irq_ack_timing: assert property (@(posedge clk) disable iff (!rst_n)
		irq_ack |-> {prev_state, prev_przerw, prev_ack} == {PK, 2'b10})
		else report_mismatch("irq_ack_timing", 64'({PK, 2'b10}),
			64'($sampled({prev_state, prev_przerw, prev_ack})));

	irq_ack_given: assert property (@(posedge clk) disable iff (!rst_n)
		prev_przerw && !status.przerw |-> irq_ack)
		else report_mismatch("irq_ack_given", 64'd1, 64'($sampled(irq_ack)));

	run_blocks_store: assert property (@(posedge clk) disable iff (!rst_n)
		status.run |-> !(mem_req.req && mem_req.we))
		else report_mismatch("run_blocks_store", 64'd0,
			64'($sampled({mem_req.req, mem_req.we})));

	req_stable: assert property (@(posedge clk) disable iff (!rst_n)
		prev_pending |-> mem_req == prev_req)
		else report_mismatch("req_stable", 64'($sampled(prev_req)), 64'($sampled(mem_req)));

	task automatic panel_command(input logic ld, input logic st, input logic fe,
			input addr_t a, input word_t d);
		@(posedge clk);
		panel <= '{load: ld, store: st, fetch: fe, addr: a, data: d};
		@(posedge clk);
		panel <= '0;
	endtask

	task automatic wait_panel_done();
		do @(posedge clk); while (!panel_done);
	endtask

	task automatic press_start();
		@(posedge clk);
		start_key <= 1'b1;
		@(posedge clk);
		start_key <= 1'b0;
	endtask

	task automatic wait_halt();
		do @(posedge clk); while (!(status.wait_q && status.state == P0));
	endtask

	// irq held until the DUT acknowledges it
	task automatic raise_irq();
		@(posedge clk);
		irq <= 1'b1;
		do @(posedge clk); while (!irq_ack);
		irq <= 1'b0;
	endtask

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		abort_run("watchdog expired, the DUT never reached the end of the test");
	end

	initial begin
		rst_n       <= 1'b0;
		start_key   <= 1'b0;
		stop_key    <= 1'b0;
		irq         <= 1'b0;
		panel       <= '0;
		idle_phase  <= 1'b1;
		fetch_armed <= 1'b0;
		fetch_value <= '0;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		repeat (4) @(posedge clk);
		idle_phase <= 1'b0;

		// panel store, fetch back, then load IC
		panel_command(1'b0, 1'b1, 1'b0, 16'h0080, 16'hbeef);
		wait_panel_done();
		fetch_value <= 16'hbeef;
		fetch_armed <= 1'b1;
		panel_command(1'b0, 1'b0, 1'b1, 16'h0080, 16'h0000);
		wait_panel_done();
		fetch_armed <= 1'b0;
		panel_command(1'b1, 1'b0, 1'b0, 16'h0010, 16'h0000);

		// program at 0x10 runs into its halt
		press_start();
		wait_halt();
		repeat (10) @(posedge clk);

		// resume, panel store while running, interrupt into the handler
		press_start();
		repeat (20) @(posedge clk);
		panel_command(1'b0, 1'b1, 1'b0, 16'h0080, 16'hdead);
		raise_irq();
		wait_halt();

		// interrupt releases a halted CPU
		repeat (5) @(posedge clk);
		raise_irq();
		wait_halt();
		repeat (5) @(posedge clk);

		irq_count: assert (ack_count == 2)
			else report_mismatch("irq_count", 64'd2, 64'(ack_count));
		store_ignored: assert (mem[8'h80] == 16'hbeef)
			else report_mismatch("store_ignored", 64'hbeef, 64'(mem[8'h80]));
		$display("Test completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

/* build.f */
logic/cpu_pkg.sv
logic/membus_pkg.sv
logic/cycle_timer.sv
logic/panel_control.sv
logic/mem_arbiter.sv
logic/state_sequencer.sv
logic/pm_top.sv
verification/pm_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module pm_tb -o pm_sim

sim_out=$(./obj_dir/pm_sim 2>&1 || true)
echo "$sim_out"
if grep -q "Test completed successfully" <<< "$sim_out"; then
	exit 0
fi
exit 1
